// ==== build.f ====
+incdir+src
src/game_pkg.sv
src/dl_ctrl.sv
src/cpu_decode.sv
src/char_vram.sv
src/palette_prom.sv
src/game_cfg_top.sv
verif/tb_game_cfg.sv

// ==== run.sh ====
#!/bin/sh
# Compile and run the game glue testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps -f build.f \
    --top-module tb_game_cfg -Mdir obj_dir -o sim_game_cfg
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_game_cfg > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "TESTS PASSED" sim.log; then
    exit 0
fi
exit 1

// ==== src/char_vram.sv ====
//**********************************************************
// Character VRAM
// 1024 x 16 bit, byte lanes for the CPU, word reads for video
//**********************************************************
`timescale 1ns/1ps
`include "game_cfg.svh"
`default_nettype none

module char_vram (
    input  wire                      clk,
    input  wire                      char_cs,
    input  wire game_pkg::cpu_bus_t  bus,
    input  wire [`VRAM_AW-1:0]       vram_addr,
    output logic [7:0]               vram_byte,
    output logic [15:0]              vram_q
);

    localparam int depth = 1 << `VRAM_AW;

    // Upper lane holds attributes, lower lane the tile code
    logic [7:0] ram_hi [depth];
    logic [7:0] ram_lo [depth];

    logic [`VRAM_AW-1:0] cpu_addr;
    logic                hi_lane;
    logic                cpu_wr;
    logic                we_hi;
    logic                we_lo;

    assign cpu_addr = bus.addr[`VRAM_AW-1:0];
    assign hi_lane  = bus.addr[`VRAM_AW];   // CPU address bit 10
    assign cpu_wr   = char_cs && !bus.wr_n;
    assign we_hi    = cpu_wr && hi_lane;
    assign we_lo    = cpu_wr && !hi_lane;

    always_ff @(posedge clk) begin
        if (we_hi) begin
            ram_hi[cpu_addr] <= bus.dout;
        end
        if (we_lo) begin
            ram_lo[cpu_addr] <= bus.dout;
        end
    end

    // CPU side lane select, registered in the decoder
    assign vram_byte = hi_lane ? ram_hi[cpu_addr] : ram_lo[cpu_addr];

    // Video port
    always_ff @(posedge clk) begin
        vram_q <= {ram_hi[vram_addr], ram_lo[vram_addr]};
    end

endmodule

`default_nettype wire

// ==== src/cpu_decode.sv ====
//**********************************************************
// CPU bus decoder
// Character VRAM select, screen flip register, effective
// flip and the registered read data for the CPU
//**********************************************************
`timescale 1ns/1ps
`include "game_cfg.svh"
`default_nettype none

module cpu_decode (
    input  wire                      clk,
    input  wire                      rst_n,
    input  wire game_pkg::cpu_bus_t  bus,
    input  wire game_pkg::cfg_t      cfg,
    input  wire                      flip_en,    // Vulgus extra DIP switch
    input  wire [7:0]                vram_byte,
    output logic                     char_cs,
    output logic [7:0]               cpu_din,
    output logic                     eff_flip
);
    import game_pkg::*;

    localparam logic [`CPU_AW-1:0] char_base = `CHAR_BASE;
    localparam logic [`CPU_AW-1:0] flip_addr = `FLIP_ADDR;

    logic flip_reg;
    logic flip_wr;
    logic vulgus_flip;

    // 2 KB window, low 11 bits go to the VRAM
    assign char_cs = (bus.addr[`CPU_AW-1:11] == char_base[`CPU_AW-1:11]);

    assign flip_wr     = !bus.wr_n && (bus.addr == flip_addr);
    assign vulgus_flip = (cfg.game_id == VULGUS) && flip_en;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            flip_reg <= 1'b0;
            eff_flip <= 1'b0;
        end else begin
            if (flip_wr) begin
                flip_reg <= bus.dout[7];
            end
            eff_flip <= vulgus_flip ^ cfg.flip_xor ^ flip_reg;
        end
    end

    // Read data is held until the next read strobe
    always_ff @(posedge clk) begin
        if (!bus.rd_n) begin
            cpu_din <= char_cs ? vram_byte : 8'hff;  // Open bus elsewhere
        end
    end

endmodule

`default_nettype wire

// ==== src/dl_ctrl.sv ====
//**********************************************************
// Download controller
// Captures the game header, remaps object ROM addresses
// and turns PROM writes into per-PROM enables
//**********************************************************
`timescale 1ns/1ps
`include "game_cfg.svh"
`default_nettype none

module dl_ctrl (
    input  wire                     clk,
    input  wire                     rst_n,
    input  wire game_pkg::prog_t    prog,
    output game_pkg::cfg_t          cfg,
    output game_pkg::prom_we_t      prom_we,
    output logic [`PROG_AW-1:0]     post_addr
);
    import game_pkg::*;

    localparam logic [`PROG_AW-1:0] hdr_len    = `HDR_LEN;
    localparam logic [`PROG_AW-1:0] obj_start  = `OBJ_START;
    localparam logic [`PROG_AW-1:0] obj_end    = `OBJ_END;
    localparam logic [`PROG_AW-1:0] prom_start = `PROM_START;

    game_id_e    game_id;
    logic        flip_xor;
    logic        hige;
    logic        hdr_wr;
    logic        prom_wr;
    logic        in_obj;
    logic [3:0]  bank;

    assign hdr_wr  = prog.we && prog.hdr && (prog.addr < hdr_len);
    assign prom_wr = prog.we && !prog.hdr && (prog.addr >= prom_start);
    assign bank    = prog.addr[11:8];

    // Header bytes: 0 is the game id, 1 carries the flip inversion
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            game_id  <= G1942;
            flip_xor <= 1'b0;
            hige     <= 1'b0;
        end else begin
            hige <= (game_id == HIGEMARU);  // One cycle behind game_id
            if (hdr_wr) begin
                case (prog.addr[0])
                    1'b0: game_id  <= game_id_e'(prog.data[1:0]);
                    1'b1: flip_xor <= prog.data[0];
                    default: ;
                endcase
            end
        end
    end

    assign cfg = '{game_id: game_id, flip_xor: flip_xor, hige: hige};

    // Object ROM data is stored with address bits 5:1 rotated,
    // Higemaru keeps its natural order
    assign in_obj = !hige && (prog.addr >= obj_start) && (prog.addr < obj_end);

    always_comb begin
        post_addr = prog.addr;
        if (in_obj) begin
            post_addr[5:1] = {prog.addr[4:1], prog.addr[5]};
        end
    end

    // PROM bank layout per game
    always_comb begin
        prom_we = '0;
        if (prom_wr) begin
            prom_we.red_we   = (bank == 4'd0);              // Also Higemaru palette
            prom_we.green_we = !hige && (bank == 4'd1);
            prom_we.blue_we  = !hige && (bank == 4'd2);
            prom_we.scr_we   = (bank == 4'd4);
            prom_we.d1_we    = (bank == 4'd6);
            prom_we.d2_we    = (bank == 4'd7);
            if (hige) begin
                // Char lookup is only 128 entries here
                prom_we.char_we = (bank == 4'd1) && !prog.addr[7];
                prom_we.obj_we  = (bank == 4'd2);
                prom_we.irq_we  = (bank == 4'd3);
            end else begin
                prom_we.char_we = (bank == 4'd3);
                prom_we.obj_we  = (bank == 4'd5);
                prom_we.irq_we  = (bank == 4'd8);
            end
        end
    end

endmodule

`default_nettype wire

// ==== src/game_cfg.svh ====
//**********************************************************
// Game glue configuration
// Address widths, download regions and CPU decode addresses
// shared by the 1942, Vulgus and Higemaru glue logic
//**********************************************************
`ifndef GAME_CFG_SVH
`define GAME_CFG_SVH

// Download stream, word addresses
`define PROG_AW     22
`define HDR_LEN     2
`define OBJ_START   22'h0_C000  // Object ROM region
`define OBJ_END     22'h1_4000
`define PROM_START  22'h2_0000  // PROM banks of 256 bytes from here on
`define PROM_AW     8

// CPU bus
`define CPU_AW      13
`define CHAR_BASE   13'h1000    // Bits 12:11 pick the 2 KB window
`define FLIP_ADDR   13'h0804
`define VRAM_AW     10

`endif

// ==== src/game_cfg_top.sv ====
//**********************************************************
// Game glue top level
// Download control, CPU decode, character VRAM and palette
//**********************************************************
`timescale 1ns/1ps
`include "game_cfg.svh"
`default_nettype none

module game_cfg_top (
    input  wire                      clk,
    input  wire                      rst_n,
    input  wire game_pkg::prog_t     prog,
    input  wire game_pkg::cpu_bus_t  bus,
    input  wire                      flip_en,
    input  wire [`VRAM_AW-1:0]       vram_addr,
    input  wire [7:0]                pix_code,
    output logic [`PROG_AW-1:0]      post_addr,
    output game_pkg::prom_we_t       prom_we,   // Also feeds the other video PROMs
    output logic [7:0]               cpu_din,
    output logic                     eff_flip,
    output logic [15:0]              vram_q,
    output logic [11:0]              rgb
);
    import game_pkg::*;

    cfg_t       cfg;
    logic       char_cs;
    logic [7:0] vram_byte;

    dl_ctrl u_dl (
        .clk        ( clk        ),
        .rst_n      ( rst_n      ),
        .prog       ( prog       ),
        .cfg        ( cfg        ),
        .prom_we    ( prom_we    ),
        .post_addr  ( post_addr  )
    );

    cpu_decode u_cpu (
        .clk        ( clk        ),
        .rst_n      ( rst_n      ),
        .bus        ( bus        ),
        .cfg        ( cfg        ),
        .flip_en    ( flip_en    ),
        .vram_byte  ( vram_byte  ),
        .char_cs    ( char_cs    ),
        .cpu_din    ( cpu_din    ),
        .eff_flip   ( eff_flip   )
    );

    char_vram u_vram (
        .clk        ( clk        ),
        .char_cs    ( char_cs    ),
        .bus        ( bus        ),
        .vram_addr  ( vram_addr  ),
        .vram_byte  ( vram_byte  ),
        .vram_q     ( vram_q     )
    );

    palette_prom u_pal (
        .clk        ( clk        ),
        .rst_n      ( rst_n      ),
        .prog       ( prog       ),
        .prom_we    ( prom_we    ),
        .cfg        ( cfg        ),
        .pix_code   ( pix_code   ),
        .rgb        ( rgb        )
    );

endmodule

`default_nettype wire

// ==== src/game_pkg.sv ====
//**********************************************************
// Game glue package
// Game id and the packed structs passed between the blocks
//**********************************************************
`include "game_cfg.svh"
`default_nettype none

package game_pkg;

    typedef enum logic [1:0] {
        G1942    = 2'd0,
        VULGUS   = 2'd1,
        HIGEMARU = 2'd2
    } game_id_e;

    // One write from the ROM download stream
    typedef struct packed {
        logic [`PROG_AW-1:0] addr;
        logic [7:0]          data;
        logic                we;
        logic                hdr;   // Header bytes come first
    } prog_t;

    // One CPU cycle, strobes active low
    typedef struct packed {
        logic [`CPU_AW-1:0] addr;
        logic [7:0]         dout;
        logic               wr_n;
        logic               rd_n;
    } cpu_bus_t;

    typedef struct packed {
        logic red_we;
        logic green_we;
        logic blue_we;
        logic char_we;
        logic scr_we;
        logic obj_we;
        logic d1_we;
        logic d2_we;
        logic irq_we;
    } prom_we_t;

    typedef struct packed {
        game_id_e game_id;
        logic     flip_xor;
        logic     hige;     // Registered copy of game_id == HIGEMARU
    } cfg_t;

endpackage

`default_nettype wire

// ==== src/palette_prom.sv ====
//**********************************************************
// Palette PROMs
// Character lookup PROM and the red, green and blue PROMs
// with a two-stage pixel colour pipeline
//**********************************************************
`timescale 1ns/1ps
`include "game_cfg.svh"
`default_nettype none

module palette_prom (
    input  wire                      clk,
    input  wire                      rst_n,
    input  wire game_pkg::prog_t     prog,
    input  wire game_pkg::prom_we_t  prom_we,
    input  wire game_pkg::cfg_t      cfg,
    input  wire [7:0]                pix_code,
    output logic [11:0]              rgb
);

    localparam int depth = 1 << `PROM_AW;

    logic [3:0] lut_rom [depth];
    logic [7:0] red_rom [depth];    // Full byte for the Higemaru palette
    logic [3:0] grn_rom [depth];
    logic [3:0] blu_rom [depth];

    logic [`PROM_AW-1:0] wr_addr;
    logic [`PROM_AW-1:0] col_addr;

    logic [3:0] lut_s1;
    logic [3:0] hi_s1;
    logic       hige_s1;
    logic [7:0] red_s2;
    logic [3:0] grn_s2;
    logic [3:0] blu_s2;
    logic       hige_s2;

    assign wr_addr = prog.addr[`PROM_AW-1:0];

    always_ff @(posedge clk) begin
        if (prom_we.char_we) begin
            lut_rom[wr_addr] <= prog.data[3:0];
        end
        if (prom_we.red_we) begin
            red_rom[wr_addr] <= prog.data;
        end
        if (prom_we.green_we) begin
            grn_rom[wr_addr] <= prog.data[3:0];
        end
        if (prom_we.blue_we) begin
            blu_rom[wr_addr] <= prog.data[3:0];
        end
    end

    assign col_addr = {hi_s1, lut_s1};

    always_ff @(posedge clk) begin
        lut_s1 <= lut_rom[pix_code];        // Stage 1 lookup
        hi_s1  <= pix_code[7:4];
        red_s2 <= red_rom[col_addr];        // Stage 2 colour
        grn_s2 <= grn_rom[col_addr];
        blu_s2 <= blu_rom[col_addr];
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hige_s1 <= 1'b0;
            hige_s2 <= 1'b0;
        end else begin
            hige_s1 <= cfg.hige;
            hige_s2 <= hige_s1;
        end
    end

    // Higemaru packs BBGGGRRR into the red bank, widened to 4 bits here
    always_comb begin
        if (hige_s2) begin
            rgb = {red_s2[2:0], red_s2[2], red_s2[5:3], red_s2[5], red_s2[7:6], red_s2[7:6]};
        end else begin
            rgb = {red_s2[3:0], grn_s2, blu_s2};
        end
    end

endmodule

`default_nettype wire

// ==== verif/tb_game_cfg.sv ====
//**********************************************************
// Game glue testbench
// Directed tests for header capture, address remap, PROM
// decode, VRAM byte lanes, flip and the palette pipeline
//**********************************************************
`timescale 1ns/1ps
`include "game_cfg.svh"
`default_nettype none

module tb_game_cfg;
    import game_pkg::*;

    localparam int timeout_cycles = 4000;  // Tests need about 1600

    logic clk;
    logic rst_n;
    prog_t prog;
    cpu_bus_t bus;
    logic flip_en;
    logic [`VRAM_AW-1:0] vram_addr;
    logic [7:0] pix_code;
    logic [`PROG_AW-1:0] post_addr;
    prom_we_t prom_we;
    logic [7:0] cpu_din;
    logic eff_flip;
    logic [15:0] vram_q;
    logic [11:0] rgb;

    logic [15:0] lfsr = 16'd84;
    int errors = 0;
    int cycles = 0;
    logic [7:0] lut_m [256];    // Models of the stored PROM tables
    logic [7:0] red_m [256];
    logic [7:0] grn_m [256];
    logic [7:0] blu_m [256];

    game_cfg_top u_dut (
        .clk(clk), .rst_n(rst_n), .prog(prog), .bus(bus), .flip_en(flip_en),
        .vram_addr(vram_addr), .pix_code(pix_code), .post_addr(post_addr),
        .prom_we(prom_we), .cpu_din(cpu_din), .eff_flip(eff_flip),
        .vram_q(vram_q), .rgb(rgb)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > timeout_cycles) begin
            $display("TESTS FAILED");
            $fatal(1, "Run did not finish within %0d cycles", timeout_cycles);
        end
    end

    // x^16 + x^14 + x^13 + x^11 + 1, one step per bit
    function automatic logic [7:0] rand_bits(input int n);
        logic [7:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
            r = {r[6:0], lfsr[0]};
        end
        return r;
    endfunction

    task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            errors = errors + 1;
            $display("FAILED %s: expected %h, actual %h", name, exp, act);
            $display("TESTS FAILED");
            $fatal(1, "Mismatch in %s", name);
        end
    endtask

    task automatic tick();
        @(posedge clk);
        #1;
    endtask

    task automatic bus_idle();
        bus = '{addr: '0, dout: 8'h00, wr_n: 1'b1, rd_n: 1'b1};
    endtask

    function automatic logic [`PROG_AW-1:0] prom_addr(input logic [3:0] bank,
                                                      input logic [7:0] off);
        logic [`PROG_AW-1:0] r;
        r = `PROM_START;
        r[11:8] = bank;
        r[7:0] = off;
        return r;
    endfunction

    // Enables expected from each game's PROM bank layout
    function automatic prom_we_t exp_we(input logic [3:0] bank, input logic hige,
                                        input logic a7);
        prom_we_t w;
        w = '0;
        case (bank)
            4'd0: w.red_we = 1'b1;
            4'd1: if (hige) w.char_we = !a7; else w.green_we = 1'b1;
            4'd2: if (hige) w.obj_we = 1'b1; else w.blue_we = 1'b1;
            4'd3: if (hige) w.irq_we = 1'b1; else w.char_we = 1'b1;
            4'd4: w.scr_we = 1'b1;
            4'd5: w.obj_we = !hige;
            4'd6: w.d1_we = 1'b1;
            4'd7: w.d2_we = 1'b1;
            4'd8: w.irq_we = !hige;
            default: ;
        endcase
        return w;
    endfunction

    // Object region rotates bits 5:1 unless the game is Higemaru
    function automatic logic [`PROG_AW-1:0] exp_remap(input logic [`PROG_AW-1:0] a,
                                                      input logic hige);
        logic [`PROG_AW-1:0] r;
        r = a;
        if (!hige && a >= `OBJ_START && a < `OBJ_END) begin
            r[1] = a[5];
            r[5:2] = a[4:1];
        end
        return r;
    endfunction

    function automatic logic [11:0] pal_model(input logic [7:0] code);
        logic [7:0] a;
        a = {code[7:4], lut_m[code][3:0]};
        return {red_m[a][3:0], grn_m[a][3:0], blu_m[a][3:0]};
    endfunction

    task automatic hdr_write(input logic [`PROG_AW-1:0] a, input logic [7:0] d);
        prog = '{addr: a, data: d, we: 1'b1, hdr: 1'b1};
        tick();
        prog = '0;
    endtask

    task automatic set_cfg(input game_id_e g, input logic fx);
        hdr_write(22'd0, {6'b0, g});
        hdr_write(22'd1, {7'b0, fx});
        tick();                             // hige and eff_flip settle
    endtask

    task automatic prom_write(input logic [3:0] bank, input logic [7:0] off,
                              input logic [7:0] d);
        prog = '{addr: prom_addr(bank, off), data: d, we: 1'b1, hdr: 1'b0};
        tick();
        prog = '0;
    endtask

    // Enables are combinational, so look before the next edge
    task automatic prom_probe(input logic [3:0] bank, input logic [7:0] off,
                              output prom_we_t seen);
        prog = '{addr: prom_addr(bank, off), data: 8'h00, we: 1'b1, hdr: 1'b0};
        #1;
        seen = prom_we;
        tick();
        prog = '0;
    endtask

    task automatic cpu_write(input logic [`CPU_AW-1:0] a, input logic [7:0] d);
        bus = '{addr: a, dout: d, wr_n: 1'b0, rd_n: 1'b1};
        tick();
        bus_idle();
    endtask

    task automatic cpu_read(input logic [`CPU_AW-1:0] a, output logic [7:0] d);
        bus = '{addr: a, dout: 8'h00, wr_n: 1'b1, rd_n: 1'b0};
        tick();
        bus_idle();
        d = cpu_din;
    endtask

    task automatic header_capture();
        prom_we_t seen;
        set_cfg(HIGEMARU, 1'b1);
        prom_probe(4'd3, 8'h10, seen);
        check("header hige layout", 32'(exp_we(4'd3, 1'b1, 1'b0)), 32'(seen));
        check("header flip_xor", 32'd1, 32'(eff_flip));
        set_cfg(G1942, 1'b0);
        prom_probe(4'd3, 8'h10, seen);
        check("header 1942 layout", 32'(exp_we(4'd3, 1'b0, 1'b0)), 32'(seen));
        check("header flip clear", 32'd0, 32'(eff_flip));
    endtask

    task automatic addr_remap();
        logic [`PROG_AW-1:0] addrs [8];
        // Bits 5:1 of each fixed address change under the rotation
        addrs[0] = `OBJ_START + 22'h02;
        addrs[1] = `OBJ_START + 22'h2A;     // Bits 5:1 = 10101
        addrs[2] = `OBJ_END - 22'h20;
        addrs[3] = `OBJ_END + 22'h02;
        addrs[4] = `OBJ_START - 22'h20;
        addrs[5] = 22'h0_0024;
        addrs[6] = `OBJ_START + {14'b0, rand_bits(8)};
        addrs[7] = `OBJ_START + {7'b0, rand_bits(8), 7'b0};
        for (int h = 0; h < 2; h++) begin
            set_cfg(game_id_e'(h != 0 ? HIGEMARU : G1942), 1'b0);
            for (int i = 0; i < 8; i++) begin
                prog = '{addr: addrs[i], data: 8'h00, we: 1'b0, hdr: 1'b0};
                #1;
                check("remap", 32'(exp_remap(addrs[i], h != 0)), 32'(post_addr));
                tick();
            end
            prog = '0;
        end
    endtask

    task automatic prom_decode();
        prom_we_t seen;
        logic [7:0] off;
        for (int h = 0; h < 2; h++) begin
            set_cfg(game_id_e'(h != 0 ? HIGEMARU : G1942), 1'b0);
            for (int b = 0; b < 9; b++) begin
                off = {1'b0, rand_bits(7)};
                prom_probe(4'(b), off, seen);
                check("prom bank", 32'(exp_we(4'(b), h != 0, 1'b0)), 32'(seen));
            end
        end
        prom_probe(4'd1, 8'h80, seen);      // Upper half of the Higemaru char bank
        check("prom hige char a7", 32'd0, 32'(seen));
    endtask

    task automatic vram_lanes();
        logic [`VRAM_AW-1:0] waddr [8];
        logic [7:0] hi_d [8];
        logic [7:0] lo_d [8];
        logic [`CPU_AW-1:0] a;
        logic [7:0] d;
        for (int i = 0; i < 8; i++) begin
            waddr[i] = 10'(i * 97 + 13);
            hi_d[i] = rand_bits(8);
            lo_d[i] = rand_bits(8);
            a = `CHAR_BASE;
            a[9:0] = waddr[i];
            cpu_write(a, lo_d[i]);
            a[10] = 1'b1;
            cpu_write(a, hi_d[i]);
        end
        for (int i = 0; i < 8; i++) begin
            a = `CHAR_BASE;
            a[9:0] = waddr[i];
            cpu_read(a, d);
            check("vram lower lane", 32'(lo_d[i]), 32'(d));
            a[10] = 1'b1;
            cpu_read(a, d);
            check("vram upper lane", 32'(hi_d[i]), 32'(d));
            vram_addr = waddr[i];
            tick();
            check("vram video word", 32'({hi_d[i], lo_d[i]}), 32'(vram_q));
        end
    endtask

    task automatic flip_rule();
        logic e;
        for (int g = 0; g < 3; g++) begin
            for (int fe = 0; fe < 2; fe++) begin
                for (int fx = 0; fx < 2; fx++) begin
                    for (int fr = 0; fr < 2; fr++) begin
                        flip_en = (fe != 0);
                        set_cfg(game_id_e'(2'(g)), fx != 0);
                        cpu_write(`FLIP_ADDR, {fr != 0, 7'h00});
                        tick();
                        e = ((g == 1) && (fe != 0)) ^ (fx != 0) ^ (fr != 0);
                        check($sformatf("flip g%0d en%0d x%0d r%0d", g, fe, fx, fr),
                              32'(e), 32'(eff_flip));
                    end
                end
            end
        end
        flip_en = 1'b0;
    endtask

    task automatic palette_pipe();
        logic [7:0] codes [256];
        set_cfg(G1942, 1'b0);
        for (int a = 0; a < 256; a++) begin
            lut_m[a] = rand_bits(8);
            red_m[a] = rand_bits(8);
            grn_m[a] = rand_bits(8);
            blu_m[a] = rand_bits(8);
            prom_write(4'd3, 8'(a), lut_m[a]);
            prom_write(4'd0, 8'(a), red_m[a]);
            prom_write(4'd1, 8'(a), grn_m[a]);
            prom_write(4'd2, 8'(a), blu_m[a]);
            codes[a] = rand_bits(8);
        end
        // One code per clock, each result two edges later
        for (int k = 0; k < 258; k++) begin
            if (k >= 2) begin
                check("palette rgb", 32'(pal_model(codes[k-2])), 32'(rgb));
            end
            if (k < 256) begin
                pix_code = codes[k];
            end
            tick();
        end
        pix_code = 8'h00;
    endtask

    initial begin
        rst_n = 1'b0;
        prog = '0;
        bus_idle();
        flip_en = 1'b0;
        vram_addr = '0;
        pix_code = 8'h00;
        repeat (5) @(posedge clk);
        #1;
        rst_n = 1'b1;
        tick();

        header_capture();
        addr_remap();
        prom_decode();
        vram_lanes();
        flip_rule();
        palette_pipe();

        if (errors == 0) begin
            $display("TESTS PASSED");
            $finish;
        end else begin
            $display("TESTS FAILED");
            $fatal(1, "%0d checks failed", errors);
        end
    end

endmodule

`default_nettype wire
